// File: hw/ahb_settings.svh
// bus widths and slave address map of the AHB fabric, included by RTL and testbench
`ifndef AHB_SETTINGS_SVH
`define AHB_SETTINGS_SVH

`define AHB_ADDR_W      32
`define AHB_DATA_W      32
`define AHB_MASTER_W    4            // hmaster width
`define AHB_NUM_MASTERS 2

// slave regions, base inclusive, base + size exclusive
`define AHB_S0_BASE     32'h0000_0000
`define AHB_S0_SIZE     32'h0001_0000
`define AHB_S1_BASE     32'h1000_0000
`define AHB_S1_SIZE     32'h0001_0000

`endif

// File: hw/ahb_pkg.sv
// bus and FSM state types of the AHB fabric, referenced with scoped names
`default_nettype none

package ahb_pkg;

  typedef enum logic [1:0] {IDLE, BUSY, NONSEQ, SEQ} htrans_e;

  typedef enum logic [1:0] {OKAY, ERROR, RETRY, SPLIT} hresp_e;

  typedef enum logic {ARB_READY, ARB_STAY} arb_state_e;

  typedef enum logic {DS_IDLE, DS_ERROR} dflt_state_e;

  // data-phase source in the response mux
  typedef enum logic [1:0] {SEL_NONE, SEL_S0, SEL_S1, SEL_DFLT} resp_sel_e;

endpackage

`default_nettype wire

// File: hw/ahb_bus_if.sv
// shared address and data phase of the fabric, passed between the internal blocks
`timescale 1ns/1ns
`default_nettype none
`include "ahb_settings.svh"

interface ahb_bus_if;
  logic [`AHB_ADDR_W-1:0] haddr;
  ahb_pkg::htrans_e       htrans;
  logic                   hwrite;
  logic [`AHB_DATA_W-1:0] hwdata;
  logic                   hready;   // shared data-phase ready

  modport source (output haddr, output htrans, output hwrite, output hwdata, input hready);
  modport resp   (output hready);
  modport sink   (input haddr, input htrans, input hwrite, input hwdata, input hready);
endinterface

`default_nettype wire

// File: hw/ahb_arbiter.sv
// fixed-priority bus arbiter with one-round mask, gives grant and the address-phase master
`timescale 1ns/1ns
`default_nettype none
`include "ahb_settings.svh"

module ahb_arbiter (
  input  logic                        HCLK,
  input  logic                        HRESETn,
  input  logic [`AHB_NUM_MASTERS-1:0] busreq,   // bit 0 highest priority
  input  logic                        hready,
  output logic [`AHB_NUM_MASTERS-1:0] grant,
  output logic [`AHB_MASTER_W-1:0]    hmaster
);

  ahb_pkg::arb_state_e         state;
  logic [`AHB_NUM_MASTERS-1:0] mask;       // 1 = skipped this round
  logic [`AHB_NUM_MASTERS-1:0] unmasked;
  logic                        owner;

  // lowest set bit wins
  function automatic logic [`AHB_NUM_MASTERS-1:0] pick(
    input logic [`AHB_NUM_MASTERS-1:0] req
  );
    return req & (-req);
  endfunction

  assign owner    = grant[1];   // one-hot grant of two masters
  assign unmasked = busreq & ~mask;

  // ----------------------------------------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      grant   <= '0;
      hmaster <= '0;
      mask    <= '0;
      state   <= ahb_pkg::ARB_READY;
    end else if (hready) begin
      hmaster <= {{(`AHB_MASTER_W-1){1'b0}}, owner};   // lags grant by one edge
      case (state)
        ahb_pkg::ARB_READY: begin
          if (|busreq) begin
            grant <= pick(busreq);
            mask  <= '0;
            state <= ahb_pkg::ARB_STAY;
          end
        end
        ahb_pkg::ARB_STAY: begin
          if (busreq == '0) begin
            grant <= '0;
            mask  <= '0;
            state <= ahb_pkg::ARB_READY;
          end else if (!busreq[owner]) begin
            if (unmasked == '0) begin
              grant <= pick(busreq);
              mask  <= '0;
            end else begin
              grant       <= pick(unmasked);
              mask[owner] <= 1'b1;   // let the other one in first
            end
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/ahb_master_mux.sv
// routes the granted master's address phase and the data-phase master's write data to the bus
`timescale 1ns/1ns
`default_nettype none
`include "ahb_settings.svh"

module ahb_master_mux (
  input  logic                     HCLK,
  input  logic                     HRESETn,
  input  logic [`AHB_MASTER_W-1:0] hmaster,
  input  logic [`AHB_ADDR_W-1:0]   m0_haddr,
  input  logic [1:0]               m0_htrans,
  input  logic                     m0_hwrite,
  input  logic [`AHB_DATA_W-1:0]   m0_hwdata,
  input  logic [`AHB_ADDR_W-1:0]   m1_haddr,
  input  logic [1:0]               m1_htrans,
  input  logic                     m1_hwrite,
  input  logic [`AHB_DATA_W-1:0]   m1_hwdata,
  ahb_bus_if.source                bus
);

  localparam logic [`AHB_MASTER_W-1:0] MST0 = 'd0;
  localparam logic [`AHB_MASTER_W-1:0] MST1 = 'd1;

  logic [`AHB_MASTER_W-1:0] hmaster_dp;   // owner of the data phase

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      hmaster_dp <= '0;
    end else if (bus.hready) begin
      hmaster_dp <= hmaster;
    end
  end

  always_comb begin
    case (hmaster)
      MST0: begin
        bus.haddr  = m0_haddr;
        bus.htrans = ahb_pkg::htrans_e'(m0_htrans);
        bus.hwrite = m0_hwrite;
      end
      MST1: begin
        bus.haddr  = m1_haddr;
        bus.htrans = ahb_pkg::htrans_e'(m1_htrans);
        bus.hwrite = m1_hwrite;
      end
      default: begin
        bus.haddr  = '1;
        bus.htrans = ahb_pkg::IDLE;
        bus.hwrite = 1'b0;
      end
    endcase
  end

  always_comb begin
    case (hmaster_dp)
      MST0:    bus.hwdata = m0_hwdata;
      MST1:    bus.hwdata = m1_hwdata;
      default: bus.hwdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/ahb_decoder.sv
// address decoder for the two slave regions, with remap swap and default select
`timescale 1ns/1ns
`default_nettype none
`include "ahb_settings.svh"

module ahb_decoder (
  ahb_bus_if.sink bus,
  input  logic    remap,
  output logic    hsel0,
  output logic    hsel1,
  output logic    hsel_dflt
);

  logic in_r0;
  logic in_r1;

  // an address below the base wraps to a large offset
  assign in_r0 = (bus.haddr - `AHB_S0_BASE) < `AHB_S0_SIZE;
  assign in_r1 = (bus.haddr - `AHB_S1_BASE) < `AHB_S1_SIZE;

  assign hsel0     = remap ? in_r1 : in_r0;   // remap swaps the slaves
  assign hsel1     = remap ? in_r0 : in_r1;
  assign hsel_dflt = ~(in_r0 | in_r1);

endmodule

`default_nettype wire

// File: hw/ahb_response_mux.sv
// registers the data-phase slave select and returns that slave's ready, response and read data
`timescale 1ns/1ns
`default_nettype none
`include "ahb_settings.svh"

module ahb_response_mux (
  input  logic                   HCLK,
  input  logic                   HRESETn,
  input  logic                   hsel0,
  input  logic                   hsel1,
  input  logic                   hsel_dflt,
  input  logic                   s0_hready,
  input  logic [1:0]             s0_hresp,
  input  logic [`AHB_DATA_W-1:0] s0_hrdata,
  input  logic                   s1_hready,
  input  logic [1:0]             s1_hresp,
  input  logic [`AHB_DATA_W-1:0] s1_hrdata,
  input  logic                   dflt_hready,
  input  ahb_pkg::hresp_e        dflt_hresp,
  ahb_bus_if.resp                bus,
  output logic [1:0]             hresp,
  output logic [`AHB_DATA_W-1:0] hrdata
);

  ahb_pkg::resp_sel_e sel;
  ahb_pkg::resp_sel_e sel_next;

  always_comb begin
    if (hsel0)
      sel_next = ahb_pkg::SEL_S0;
    else if (hsel1)
      sel_next = ahb_pkg::SEL_S1;
    else if (hsel_dflt)
      sel_next = ahb_pkg::SEL_DFLT;
    else
      sel_next = ahb_pkg::SEL_NONE;
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      sel <= ahb_pkg::SEL_NONE;
    end else if (bus.hready) begin
      sel <= sel_next;
    end
  end

  always_comb begin
    case (sel)
      ahb_pkg::SEL_S0: begin
        bus.hready = s0_hready;
        hresp      = s0_hresp;
        hrdata     = s0_hrdata;
      end
      ahb_pkg::SEL_S1: begin
        bus.hready = s1_hready;
        hresp      = s1_hresp;
        hrdata     = s1_hrdata;
      end
      ahb_pkg::SEL_DFLT: begin
        bus.hready = dflt_hready;
        hresp      = dflt_hresp;
        hrdata     = '0;   // default slave returns no data
      end
      default: begin
        bus.hready = 1'b1;
        hresp      = ahb_pkg::ERROR;
        hrdata     = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hw/ahb_default_slave.sv
// default slave answering unmapped NONSEQ or SEQ transfers with a two-cycle ERROR response
`timescale 1ns/1ns
`default_nettype none

module ahb_default_slave (
  input  logic            HCLK,
  input  logic            HRESETn,
  input  logic            hsel,
  ahb_bus_if.sink         bus,
  output logic            hready_out,
  output ahb_pkg::hresp_e hresp
);

  ahb_pkg::dflt_state_e state;
  logic                 active;

  assign active = (bus.htrans == ahb_pkg::NONSEQ) || (bus.htrans == ahb_pkg::SEQ);

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      hready_out <= 1'b1;
      hresp      <= ahb_pkg::OKAY;
      state      <= ahb_pkg::DS_IDLE;
    end else begin
      case (state)
        ahb_pkg::DS_IDLE: begin
          if (hsel && bus.hready && active) begin
            hready_out <= 1'b0;   // first error cycle, wait
            hresp      <= ahb_pkg::ERROR;
            state      <= ahb_pkg::DS_ERROR;
          end else begin
            hready_out <= 1'b1;
            hresp      <= ahb_pkg::OKAY;
          end
        end
        ahb_pkg::DS_ERROR: begin
          hready_out <= 1'b1;   // second error cycle ends it
          hresp      <= ahb_pkg::ERROR;
          state      <= ahb_pkg::DS_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/ahb_bus_m2s2.sv
// top of the two-master two-slave AHB fabric, connects arbiter, muxes, decoder and default slave
`timescale 1ns/1ns
`default_nettype none
`include "ahb_settings.svh"

module ahb_bus_m2s2 (
  input  logic                     HCLK,
  input  logic                     HRESETn,
  // ----------------------------------------------------------------------
  input  logic                     m0_busreq,
  input  logic [`AHB_ADDR_W-1:0]   m0_haddr,
  input  logic [1:0]               m0_htrans,
  input  logic                     m0_hwrite,
  input  logic [`AHB_DATA_W-1:0]   m0_hwdata,
  output logic                     m0_hgrant,
  input  logic                     m1_busreq,
  input  logic [`AHB_ADDR_W-1:0]   m1_haddr,
  input  logic [1:0]               m1_htrans,
  input  logic                     m1_hwrite,
  input  logic [`AHB_DATA_W-1:0]   m1_hwdata,
  output logic                     m1_hgrant,
  output logic [`AHB_DATA_W-1:0]   m_hrdata,
  output logic [1:0]               m_hresp,
  output logic                     m_hready,
  // ----------------------------------------------------------------------
  output logic [`AHB_ADDR_W-1:0]   s_haddr,
  output logic [1:0]               s_htrans,
  output logic                     s_hwrite,
  output logic [`AHB_DATA_W-1:0]   s_hwdata,
  output logic                     s_hready,
  output logic [`AHB_MASTER_W-1:0] s_hmaster,
  output logic                     s0_hsel,
  output logic                     s1_hsel,
  input  logic                     s0_hready,
  input  logic [1:0]               s0_hresp,
  input  logic [`AHB_DATA_W-1:0]   s0_hrdata,
  input  logic                     s1_hready,
  input  logic [1:0]               s1_hresp,
  input  logic [`AHB_DATA_W-1:0]   s1_hrdata,
  input  logic                     remap
);

  ahb_bus_if bus ();

  logic [`AHB_NUM_MASTERS-1:0] grant;
  logic [`AHB_MASTER_W-1:0]    hmaster;
  logic                        hsel0;
  logic                        hsel1;
  logic                        hsel_dflt;
  logic                        dflt_hready;
  ahb_pkg::hresp_e             dflt_hresp;

  assign {m1_hgrant, m0_hgrant} = grant;
  assign s_hmaster = hmaster;
  assign s0_hsel   = hsel0;
  assign s1_hsel   = hsel1;
  assign s_haddr   = bus.haddr;
  assign s_htrans  = bus.htrans;
  assign s_hwrite  = bus.hwrite;
  assign s_hwdata  = bus.hwdata;
  assign s_hready  = bus.hready;
  assign m_hready  = bus.hready;

  ahb_arbiter u_arbiter (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .busreq  ({m1_busreq, m0_busreq}),
    .hready  (bus.hready),
    .grant   (grant),
    .hmaster (hmaster)
  );

  ahb_master_mux u_master_mux (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .hmaster   (hmaster),
    .m0_haddr  (m0_haddr),
    .m0_htrans (m0_htrans),
    .m0_hwrite (m0_hwrite),
    .m0_hwdata (m0_hwdata),
    .m1_haddr  (m1_haddr),
    .m1_htrans (m1_htrans),
    .m1_hwrite (m1_hwrite),
    .m1_hwdata (m1_hwdata),
    .bus       (bus.source)
  );

  ahb_decoder u_decoder (
    .bus       (bus.sink),
    .remap     (remap),
    .hsel0     (hsel0),
    .hsel1     (hsel1),
    .hsel_dflt (hsel_dflt)
  );

  ahb_response_mux u_response_mux (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .hsel0       (hsel0),
    .hsel1       (hsel1),
    .hsel_dflt   (hsel_dflt),
    .s0_hready   (s0_hready),
    .s0_hresp    (s0_hresp),
    .s0_hrdata   (s0_hrdata),
    .s1_hready   (s1_hready),
    .s1_hresp    (s1_hresp),
    .s1_hrdata   (s1_hrdata),
    .dflt_hready (dflt_hready),
    .dflt_hresp  (dflt_hresp),
    .bus         (bus.resp),
    .hresp       (m_hresp),
    .hrdata      (m_hrdata)
  );

  ahb_default_slave u_default_slave (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .hsel       (hsel_dflt),
    .bus        (bus.sink),
    .hready_out (dflt_hready),
    .hresp      (dflt_hresp)
  );

endmodule

`default_nettype wire

// File: sim/ahb_bus_checker.sv
// concurrent checks on the fabric top, attached to every ahb_bus_m2s2 with bind
`timescale 1ns/1ns
`default_nettype none
`include "ahb_settings.svh"

module ahb_bus_checker (
  input logic                     HCLK,
  input logic                     HRESETn,
  input logic                     m0_hgrant,
  input logic                     m1_hgrant,
  input logic                     m_hready,
  input logic [`AHB_MASTER_W-1:0] s_hmaster,
  input logic                     s0_hsel,
  input logic                     s1_hsel,
  input logic                     hsel_dflt
);

  int fail_count = 0;

  grant_one_hot: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !(m0_hgrant && m1_hgrant))
    else begin
      fail_count = fail_count + 1;
      $error("both grants high at the same time");
    end

  // wait states freeze the arbiter
  grant_held_in_wait: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !m_hready |=> $stable({m1_hgrant, m0_hgrant, s_hmaster}))
    else begin
      fail_count = fail_count + 1;
      $error("grant or hmaster changed while hready was low");
    end

  sel_at_most_one: assert property (@(posedge HCLK) disable iff (!HRESETn)
    $onehot0({s0_hsel, s1_hsel, hsel_dflt}))
    else begin
      fail_count = fail_count + 1;
      $error("more than one slave select high");
    end

endmodule

bind ahb_bus_m2s2 ahb_bus_checker u_checker (
  .HCLK      (HCLK),
  .HRESETn   (HRESETn),
  .m0_hgrant (m0_hgrant),
  .m1_hgrant (m1_hgrant),
  .m_hready  (m_hready),
  .s_hmaster (s_hmaster),
  .s0_hsel   (s0_hsel),
  .s1_hsel   (s1_hsel),
  .hsel_dflt (hsel_dflt)
);

`default_nettype wire

// File: sim/ahb_bus_scoreboard.sv
// reference model of the fabric, compares the DUT outputs on every falling clock edge
`timescale 1ns/1ns
`default_nettype none
`include "ahb_settings.svh"

module ahb_bus_scoreboard (
  input  logic                     HCLK,
  input  logic                     HRESETn,
  input  logic                     remap,
  input  logic [1:0]               busreq,
  input  logic [`AHB_ADDR_W-1:0]   haddr [2],
  input  logic [1:0]               htrans [2],
  input  logic [1:0]               hwrite,
  input  logic [`AHB_DATA_W-1:0]   hwdata [2],
  input  logic [1:0]               slv_hready,
  input  logic [1:0]               slv_hresp [2],
  input  logic [`AHB_DATA_W-1:0]   slv_hrdata [2],
  input  logic                     m0_hgrant,
  input  logic                     m1_hgrant,
  input  logic [`AHB_DATA_W-1:0]   m_hrdata,
  input  logic [1:0]               m_hresp,
  input  logic                     m_hready,
  input  logic [`AHB_ADDR_W-1:0]   s_haddr,
  input  logic [1:0]               s_htrans,
  input  logic                     s_hwrite,
  input  logic [`AHB_DATA_W-1:0]   s_hwdata,
  input  logic                     s_hready,
  input  logic [`AHB_MASTER_W-1:0] s_hmaster,
  input  logic                     s0_hsel,
  input  logic                     s1_hsel,
  output int                       error_count
);

  ahb_pkg::arb_state_e    arb_state;
  logic [1:0]             grant;
  logic [1:0]             mask;
  logic                   hmaster;      // address-phase master index
  logic                   hmaster_dp;   // data-phase master index
  ahb_pkg::resp_sel_e     sel;
  ahb_pkg::dflt_state_e   ds_state;
  logic                   ds_hready;
  logic [1:0]             ds_hresp;
  int                     errors = 0;

  logic [`AHB_ADDR_W-1:0] exp_haddr;
  logic [1:0]             exp_htrans;
  logic                   exp_hwrite;
  logic [`AHB_DATA_W-1:0] exp_hwdata;
  logic                   in_r0;
  logic                   in_r1;
  logic                   exp_hsel0;
  logic                   exp_hsel1;
  logic                   exp_dflt;
  logic                   active;
  logic                   exp_hready;
  logic [1:0]             exp_hresp;
  logic [`AHB_DATA_W-1:0] exp_hrdata;

  assign error_count = errors;

  function automatic logic [1:0] lowest_req(input logic [1:0] req);
    if (req[0])
      return 2'b01;
    else if (req[1])
      return 2'b10;
    else
      return 2'b00;
  endfunction

  function automatic logic in_region(input logic [`AHB_ADDR_W-1:0] addr,
                                     input logic [`AHB_ADDR_W-1:0] base,
                                     input logic [`AHB_ADDR_W-1:0] size);
    return (addr >= base) && (addr < base + size);
  endfunction

  task automatic check_value(input string test, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      errors = errors + 1;
      $display("Error %s %s at %0t: expected %0h, actual %0h",
               test, field, $time, expected, actual);
    end
  endtask

  // ----------------------------------------------------------------------
  always_comb begin
    exp_haddr  = haddr[hmaster];
    exp_htrans = htrans[hmaster];
    exp_hwrite = hwrite[hmaster];
    exp_hwdata = hwdata[hmaster_dp];
    in_r0 = in_region(exp_haddr, `AHB_S0_BASE, `AHB_S0_SIZE);
    in_r1 = in_region(exp_haddr, `AHB_S1_BASE, `AHB_S1_SIZE);
    exp_hsel0 = remap ? in_r1 : in_r0;
    exp_hsel1 = remap ? in_r0 : in_r1;
    exp_dflt  = !in_r0 && !in_r1;
    active = (exp_htrans == ahb_pkg::NONSEQ) || (exp_htrans == ahb_pkg::SEQ);
    case (sel)
      ahb_pkg::SEL_S0: begin
        exp_hready = slv_hready[0];
        exp_hresp  = slv_hresp[0];
        exp_hrdata = slv_hrdata[0];
      end
      ahb_pkg::SEL_S1: begin
        exp_hready = slv_hready[1];
        exp_hresp  = slv_hresp[1];
        exp_hrdata = slv_hrdata[1];
      end
      ahb_pkg::SEL_DFLT: begin
        exp_hready = ds_hready;
        exp_hresp  = ds_hresp;
        exp_hrdata = '0;
      end
      default: begin
        exp_hready = 1'b1;   // nothing selected yet
        exp_hresp  = ahb_pkg::ERROR;
        exp_hrdata = '0;
      end
    endcase
  end

  // ----------------------------------------------------------------------
  always @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      arb_state  <= ahb_pkg::ARB_READY;
      grant      <= 2'b00;
      mask       <= 2'b00;
      hmaster    <= 1'b0;
      hmaster_dp <= 1'b0;
      sel        <= ahb_pkg::SEL_NONE;
      ds_state   <= ahb_pkg::DS_IDLE;
      ds_hready  <= 1'b1;
      ds_hresp   <= ahb_pkg::OKAY;
    end else begin
      if (ds_state == ahb_pkg::DS_ERROR) begin
        ds_hready <= 1'b1;
        ds_hresp  <= ahb_pkg::ERROR;
        ds_state  <= ahb_pkg::DS_IDLE;
      end else if (exp_dflt && exp_hready && active) begin
        ds_hready <= 1'b0;
        ds_hresp  <= ahb_pkg::ERROR;
        ds_state  <= ahb_pkg::DS_ERROR;
      end else begin
        ds_hready <= 1'b1;
        ds_hresp  <= ahb_pkg::OKAY;
      end
      if (exp_hready) begin
        hmaster    <= grant[1];
        hmaster_dp <= hmaster;
        sel <= exp_hsel0 ? ahb_pkg::SEL_S0 : (exp_hsel1 ? ahb_pkg::SEL_S1 : ahb_pkg::SEL_DFLT);
        if (busreq == 2'b00) begin
          grant     <= 2'b00;
          mask      <= 2'b00;
          arb_state <= ahb_pkg::ARB_READY;
        end else if (arb_state == ahb_pkg::ARB_READY) begin
          grant     <= lowest_req(busreq);
          mask      <= 2'b00;
          arb_state <= ahb_pkg::ARB_STAY;
        end else if (!busreq[grant[1]]) begin   // owner let go
          if ((busreq & ~mask) == 2'b00) begin
            grant <= lowest_req(busreq);
            mask  <= 2'b00;
          end else begin
            grant          <= lowest_req(busreq & ~mask);
            mask[grant[1]] <= 1'b1;
          end
        end
      end
    end
  end

  always @(negedge HCLK) begin
    check_value("arbitration", "grant", 32'(grant), 32'({m1_hgrant, m0_hgrant}));
    check_value("master_number", "hmaster", 32'(hmaster), 32'(s_hmaster));
    check_value("address_route", "haddr", exp_haddr, s_haddr);
    check_value("address_route", "htrans", 32'(exp_htrans), 32'(s_htrans));
    check_value("address_route", "hwrite", 32'(exp_hwrite), 32'(s_hwrite));
    check_value("write_data_route", "hwdata", exp_hwdata, s_hwdata);
    check_value("decode_remap", "hsel", 32'({exp_hsel1, exp_hsel0}), 32'({s1_hsel, s0_hsel}));
    check_value("response_route", "m_hready", 32'(exp_hready), 32'(m_hready));
    check_value("response_route", "s_hready", 32'(exp_hready), 32'(s_hready));
    check_value("response_route", "hresp", 32'(exp_hresp), 32'(m_hresp));
    check_value("response_route", "hrdata", exp_hrdata, m_hrdata);
  end

endmodule

`default_nettype wire

// File: sim/tb_ahb_bus.sv
// testbench top, drives random masters and slaves into the fabric and prints the verdict
`timescale 1ns/1ns
`default_nettype none
`include "ahb_settings.svh"

module tb_ahb_bus;

  localparam int NUM_CYCLES = 2000;
  localparam int CLK_PERIOD = 4;

  logic                     HCLK = 1'b0;
  logic                     HRESETn;
  logic                     remap;
  logic [1:0]               busreq;
  logic [`AHB_ADDR_W-1:0]   haddr [2];
  logic [1:0]               htrans [2];
  logic [1:0]               hwrite;
  logic [`AHB_DATA_W-1:0]   hwdata [2];
  logic [1:0]               slv_hready;
  logic [1:0]               slv_hresp [2];
  logic [`AHB_DATA_W-1:0]   slv_hrdata [2];

  logic                     m0_hgrant;
  logic                     m1_hgrant;
  logic [`AHB_DATA_W-1:0]   m_hrdata;
  logic [1:0]               m_hresp;
  logic                     m_hready;
  logic [`AHB_ADDR_W-1:0]   s_haddr;
  logic [1:0]               s_htrans;
  logic                     s_hwrite;
  logic [`AHB_DATA_W-1:0]   s_hwdata;
  logic                     s_hready;
  logic [`AHB_MASTER_W-1:0] s_hmaster;
  logic                     s0_hsel;
  logic                     s1_hsel;
  int                       sb_errors;
  integer                   seed;

  always #(CLK_PERIOD / 2) HCLK = ~HCLK;

  ahb_bus_m2s2 DUT (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .m0_busreq (busreq[0]),
    .m0_haddr  (haddr[0]),
    .m0_htrans (htrans[0]),
    .m0_hwrite (hwrite[0]),
    .m0_hwdata (hwdata[0]),
    .m0_hgrant (m0_hgrant),
    .m1_busreq (busreq[1]),
    .m1_haddr  (haddr[1]),
    .m1_htrans (htrans[1]),
    .m1_hwrite (hwrite[1]),
    .m1_hwdata (hwdata[1]),
    .m1_hgrant (m1_hgrant),
    .m_hrdata  (m_hrdata),
    .m_hresp   (m_hresp),
    .m_hready  (m_hready),
    .s_haddr   (s_haddr),
    .s_htrans  (s_htrans),
    .s_hwrite  (s_hwrite),
    .s_hwdata  (s_hwdata),
    .s_hready  (s_hready),
    .s_hmaster (s_hmaster),
    .s0_hsel   (s0_hsel),
    .s1_hsel   (s1_hsel),
    .s0_hready (slv_hready[0]),
    .s0_hresp  (slv_hresp[0]),
    .s0_hrdata (slv_hrdata[0]),
    .s1_hready (slv_hready[1]),
    .s1_hresp  (slv_hresp[1]),
    .s1_hrdata (slv_hrdata[1]),
    .remap     (remap)
  );

  ahb_bus_scoreboard u_scoreboard (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .remap       (remap),
    .busreq      (busreq),
    .haddr       (haddr),
    .htrans      (htrans),
    .hwrite      (hwrite),
    .hwdata      (hwdata),
    .slv_hready  (slv_hready),
    .slv_hresp   (slv_hresp),
    .slv_hrdata  (slv_hrdata),
    .m0_hgrant   (m0_hgrant),
    .m1_hgrant   (m1_hgrant),
    .m_hrdata    (m_hrdata),
    .m_hresp     (m_hresp),
    .m_hready    (m_hready),
    .s_haddr     (s_haddr),
    .s_htrans    (s_htrans),
    .s_hwrite    (s_hwrite),
    .s_hwdata    (s_hwdata),
    .s_hready    (s_hready),
    .s_hmaster   (s_hmaster),
    .s0_hsel     (s0_hsel),
    .s1_hsel     (s1_hsel),
    .error_count (sb_errors)
  );

  // region 0, region 1, just past region 0, or high unmapped space
  function automatic logic [`AHB_ADDR_W-1:0] pick_addr();
    case ({$random(seed)} % 4)
      0:       return `AHB_S0_BASE + ({$random(seed)} % `AHB_S0_SIZE);
      1:       return `AHB_S1_BASE + ({$random(seed)} % `AHB_S1_SIZE);
      2:       return `AHB_S0_BASE + `AHB_S0_SIZE + ({$random(seed)} % 32'h0000_fff0);
      default: return 32'hf000_0000 | {$random(seed)};
    endcase
  endfunction

  task automatic init_inputs();
    HRESETn    = 1'b0;
    remap      = 1'b0;
    busreq     = 2'b00;
    hwrite     = 2'b00;
    slv_hready = 2'b11;
    for (int i = 0; i < `AHB_NUM_MASTERS; i++) begin
      haddr[i]      = '0;
      htrans[i]     = ahb_pkg::IDLE;
      hwdata[i]     = '0;
      slv_hresp[i]  = ahb_pkg::OKAY;
      slv_hrdata[i] = '0;
    end
  endtask

  task automatic drive_random();
    for (int i = 0; i < `AHB_NUM_MASTERS; i++) begin
      busreq[i]     <= ({$random(seed)} % 3) != 0;
      haddr[i]      <= pick_addr();
      htrans[i]     <= 2'($random(seed));
      hwrite[i]     <= 1'($random(seed));
      hwdata[i]     <= $random(seed);
      slv_hready[i] <= ({$random(seed)} % 4) != 0;   // about one wait state in four
      slv_hresp[i]  <= ({$random(seed)} % 8 == 0) ? ahb_pkg::ERROR : ahb_pkg::OKAY;
      slv_hrdata[i] <= $random(seed);
    end
    if ({$random(seed)} % 64 == 0)
      remap <= ~remap;
  endtask

  initial begin
    seed = 27325;
    init_inputs();
    repeat (2) @(posedge HCLK);
    HRESETn <= 1'b1;
    repeat (NUM_CYCLES) begin
      @(posedge HCLK);
      drive_random();
    end
    @(negedge HCLK);   // last compare
    #1;
    $display("errors: model %0d, checker %0d", sb_errors, DUT.u_checker.fail_count);
    if (sb_errors == 0 && DUT.u_checker.fail_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    #((NUM_CYCLES + 2) * CLK_PERIOD + 200);
    $display("watchdog: the run did not end within %0d ns", $time);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+hw
hw/ahb_pkg.sv
hw/ahb_bus_if.sv
hw/ahb_arbiter.sv
hw/ahb_master_mux.sv
hw/ahb_decoder.sv
hw/ahb_response_mux.sv
hw/ahb_default_slave.sv
hw/ahb_bus_m2s2.sv
sim/ahb_bus_checker.sv
sim/ahb_bus_scoreboard.sv
sim/tb_ahb_bus.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_ahb_bus
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := PASS: all tests

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
